// File: Bender.yml
package:
  name: mips_core

sources:
  - common/mips_pkg.sv
  - control/instr_decoder.sv
  - control/control_unit.sv
  - datapath/reg_file.sv
  - datapath/alu.sv
  - datapath/datapath.sv
  - hdl/mips_core.sv
  - target: test
    files:
      - test/mem_model.sv
      - test/tb_mips_core.sv

// File: common/mips_pkg.sv
// shared widths, opcodes, enums and structs for the multicycle mips core, pulled in by import
package mips_pkg;

    localparam int data_w     = 32;
    localparam int reg_addr_w = 5;

    typedef logic [data_w-1:0]     word_t;      // data word and byte address
    typedef logic [reg_addr_w-1:0] reg_idx_t;   // register file index
    typedef logic [5:0]            opcode_t;
    typedef logic [5:0]            funct_t;
    typedef logic [15:0]           imm_t;       // raw i-type immediate

    // primary opcodes, ir[31:26]
    localparam opcode_t op_rtype = 6'd0;
    localparam opcode_t op_j     = 6'd2;
    localparam opcode_t op_beq   = 6'd4;
    localparam opcode_t op_addi  = 6'd8;
    localparam opcode_t op_lw    = 6'd35;
    localparam opcode_t op_sw    = 6'd43;

    // r-type funct codes, ir[5:0]
    localparam funct_t fn_add = 6'd32;
    localparam funct_t fn_sub = 6'd34;
    localparam funct_t fn_and = 6'd36;
    localparam funct_t fn_or  = 6'd37;
    localparam funct_t fn_slt = 6'd42;

    typedef enum logic [3:0] {
        alu_and = 4'd0,
        alu_sub = 4'd1,    // also the beq compare
        alu_add = 4'd2,    // pc+4, addresses, addi
        alu_or  = 4'd3,
        alu_slt = 4'd4     // signed
    } alu_op_t;

    // second alu operand
    typedef enum logic [1:0] {
        srcb_reg     = 2'd0,   // b register
        srcb_four    = 2'd1,   // pc increment
        srcb_imm     = 2'd2,   // sign-extended imm
        srcb_imm_sl2 = 2'd3    // branch word offset
    } srcb_sel_t;

    typedef enum logic [3:0] {
        idle,
        fetch,
        decode,
        determine_execution,
        execute,
        write_back_reg,
        get_effective_addr,
        store_or_load,
        store,
        load,
        branch_get_addr,
        branch_compare,
        jump
    } cu_state_t;

    // instruction class and per-instruction selects
    typedef struct packed {
        logic      is_r;
        logic      is_i;
        logic      is_j;
        logic      is_lw;
        logic      is_sw;
        logic      is_beq;
        logic      is_addi;
        logic      reg_dst;    // 1 = rd, 0 = rt
        srcb_sel_t srcb;
        alu_op_t   alu_op;
    } decode_t;

    // datapath controls, one set per state
    typedef struct packed {
        logic      pc_write;        // pc <= alu result
        logic      branch;          // gated with zero in the datapath
        logic      pc_src_aluout;
        logic      jump;
        logic      ior_d;           // memory address from alu-out
        logic      mem_write;
        logic      ir_write;
        logic      data_write;
        logic      rdx_en;          // capture a/b from the register file
        logic      aluout_en;
        logic      reg_write;
        logic      mem_to_reg;
        logic      reg_dst;
        logic      srca_reg;        // 1 = a register, 0 = pc
        srcb_sel_t srcb;
        alu_op_t   alu_op;
    } ctrl_t;

    typedef struct packed {
        word_t addr;    // byte address
        word_t wdata;
        logic  we;
    } mem_req_t;

endpackage

// File: control/control_unit.sv
// multicycle state machine sequencing fetch, decode and execute paths, drives datapath controls
`timescale 1ns/1ps

module control_unit import mips_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  opcode_t opcode,
    input  funct_t  funct,
    output ctrl_t   ctrl
);

    cu_state_t state;
    cu_state_t state_next;
    decode_t   dec;

    instr_decoder u_decoder
    (
        .opcode (opcode),
        .funct  (funct),
        .dec    (dec)
    );

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
            state <= idle;
        else
            state <= state_next;   // one state per clock
    end

    // next state
    always_comb
    begin
        case (state)
            idle:                state_next = fetch;
            fetch:               state_next = decode;
            decode:              state_next = determine_execution;
            determine_execution:
            begin
                if (dec.is_r)
                    state_next = execute;
                else if (dec.is_i)
                begin
                    if (dec.is_beq)
                        state_next = branch_get_addr;
                    else if (dec.is_addi)
                        state_next = execute;
                    else
                        state_next = get_effective_addr;   // lw and sw share this
                end
                else if (dec.is_j)
                    state_next = jump;
                else
                    state_next = fetch;    // unknown instruction is skipped
            end
            execute:             state_next = write_back_reg;
            write_back_reg:      state_next = fetch;
            get_effective_addr:  state_next = store_or_load;
            store_or_load:
            begin
                if (dec.is_sw)
                    state_next = store;
                else if (dec.is_lw)
                    state_next = load;
                else
                    state_next = fetch;
            end
            store:               state_next = fetch;
            load:                state_next = write_back_reg;   // data reg now holds the word
            branch_get_addr:     state_next = branch_compare;
            branch_compare:      state_next = fetch;
            jump:                state_next = fetch;
            default:             state_next = idle;
        endcase
    end

    // moore outputs from the registered state
    always_comb
    begin
        ctrl = '0;
        case (state)
            fetch:
            begin
                ctrl.ir_write = 1'b1;        // ir <= mem[pc]
                ctrl.srcb     = srcb_four;
                ctrl.alu_op   = alu_add;
                ctrl.pc_write = 1'b1;        // pc <= pc + 4
            end
            decode:
                ctrl.rdx_en = 1'b1;          // latch rs/rt reads
            execute:
            begin
                ctrl.srca_reg  = 1'b1;
                ctrl.srcb      = dec.srcb;
                ctrl.alu_op    = dec.alu_op;
                ctrl.aluout_en = 1'b1;
            end
            write_back_reg:
            begin
                ctrl.reg_write  = 1'b1;
                ctrl.reg_dst    = dec.reg_dst;
                ctrl.mem_to_reg = dec.is_lw;   // lw writes the data reg
            end
            get_effective_addr:
            begin
                ctrl.srca_reg  = 1'b1;
                ctrl.srcb      = srcb_imm;
                ctrl.alu_op    = alu_add;
                ctrl.aluout_en = 1'b1;
            end
            store:
            begin
                ctrl.ior_d     = 1'b1;
                ctrl.mem_write = 1'b1;       // b reg to mem[aluout]
            end
            load:
            begin
                ctrl.ior_d      = 1'b1;
                ctrl.data_write = 1'b1;
            end
            branch_get_addr:
            begin
                ctrl.srcb      = srcb_imm_sl2;   // pc already +4
                ctrl.alu_op    = alu_add;
                ctrl.aluout_en = 1'b1;
            end
            branch_compare:
            begin
                ctrl.srca_reg      = 1'b1;
                ctrl.srcb          = srcb_reg;
                ctrl.alu_op        = alu_sub;
                ctrl.branch        = 1'b1;
                ctrl.pc_src_aluout = 1'b1;   // target from alu-out
            end
            jump:
                ctrl.jump = 1'b1;
            default:
                ctrl = '0;                   // idle and wait states drive nothing
        endcase
    end

    // memory writes only come out of store, entered from store_or_load
    a_store_only: assert property (@(posedge clk) disable iff (!reset)
        ctrl.mem_write |-> (state == store) && ($past(state) == store_or_load));

    a_state_legal: assert property (@(posedge clk) disable iff (!reset)
        !$isunknown(state) && (state <= jump));

endmodule

// File: control/instr_decoder.sv
// combinational opcode/funct decode into class flags and operand selects for the control unit
`timescale 1ns/1ps

module instr_decoder import mips_pkg::*;
(
    input  opcode_t opcode,
    input  funct_t  funct,
    output decode_t dec
);

    always_comb
    begin
        dec        = '0;          // no class, rt dest, b operand
        dec.alu_op = alu_add;     // address and addi default
        case (opcode)
            op_rtype:
            begin
                dec.is_r    = 1'b1;
                dec.reg_dst = 1'b1;    // write rd
                case (funct)
                    fn_add:  dec.alu_op = alu_add;
                    fn_sub:  dec.alu_op = alu_sub;
                    fn_and:  dec.alu_op = alu_and;
                    fn_or:   dec.alu_op = alu_or;
                    fn_slt:  dec.alu_op = alu_slt;
                    default: dec.alu_op = alu_add;   // unsupported funct acts as add
                endcase
            end
            op_addi:
            begin
                dec.is_i    = 1'b1;
                dec.is_addi = 1'b1;
                dec.srcb    = srcb_imm;
            end
            op_lw:
            begin
                dec.is_i  = 1'b1;
                dec.is_lw = 1'b1;
                dec.srcb  = srcb_imm;  // base + offset
            end
            op_sw:
            begin
                dec.is_i  = 1'b1;
                dec.is_sw = 1'b1;
                dec.srcb  = srcb_imm;
            end
            op_beq:
            begin
                dec.is_i   = 1'b1;
                dec.is_beq = 1'b1;
                dec.alu_op = alu_sub;  // rs - rt, zero means equal
            end
            op_j:
            begin
                dec.is_j = 1'b1;
            end
            default:
                ;    // unknown opcode leaves every class flag low
        endcase
    end

endmodule

// File: datapath/alu.sv
// combinational alu for add, sub, and, or and signed slt, zero flag for beq
`timescale 1ns/1ps

module alu import mips_pkg::*;
(
    input  word_t   a,
    input  word_t   b,
    input  alu_op_t op,
    output word_t   y,
    output logic    zero
);

    logic lt;    // signed a < b

    assign lt = $signed(a) < $signed(b);

    always_comb
    begin
        case (op)
            alu_add:
                y = a + b;      // wraps, no overflow trap
            alu_sub:
                y = a - b;
            alu_and:
                y = a & b;
            alu_or:
                y = a | b;
            alu_slt:
                y = {{(data_w-1){1'b0}}, lt};
            default:
                y = '0;
        endcase
    end

    assign zero = (y == '0);

endmodule

// File: datapath/datapath.sv
// multicycle datapath holding pc, ir, data, a/b and alu-out registers, instanced by the core
`timescale 1ns/1ps

module datapath import mips_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  ctrl_t    ctrl,
    output opcode_t  opcode,
    output funct_t   funct,
    output mem_req_t mem_req,
    input  word_t    mem_rdata
);

    word_t    pc_q;
    word_t    ir_q;
    word_t    mdr_q;       // load data
    word_t    a_q;
    word_t    b_q;
    word_t    aluout_q;
    word_t    rd1;
    word_t    rd2;
    word_t    srca;
    word_t    srcb;
    word_t    alu_y;
    logic     alu_zero;
    word_t    imm_ext;
    word_t    jump_target;
    word_t    pc_next;
    logic     pc_en;
    imm_t     imm;
    reg_idx_t wa;
    word_t    wd;

    // instruction fields
    assign opcode  = ir_q[31:26];
    assign funct   = ir_q[5:0];
    assign imm     = ir_q[15:0];
    assign imm_ext = {{(data_w-16){imm[15]}}, imm};
    assign jump_target = {pc_q[31:28], ir_q[25:0], 2'b00};   // pc holds pc+4 here

    // program counter and instruction register
    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            pc_q <= '0;    // first fetch at 0
            ir_q <= '0;
        end
        else
        begin
            if (pc_en)
                pc_q <= pc_next;
            if (ctrl.ir_write)
                ir_q <= mem_rdata;
        end
    end

    always_ff @(posedge clk)
    begin
        if (ctrl.data_write)
            mdr_q <= mem_rdata;
        if (ctrl.rdx_en)
        begin
            a_q <= rd1;
            b_q <= rd2;
        end
        if (ctrl.aluout_en)
            aluout_q <= alu_y;
    end

    // taken beq needs zero from the compare in the same cycle
    assign pc_en = ctrl.pc_write | (ctrl.branch & alu_zero) | ctrl.jump;

    always_comb
    begin
        if (ctrl.jump)
            pc_next = jump_target;
        else if (ctrl.pc_src_aluout)
            pc_next = aluout_q;     // branch target
        else
            pc_next = alu_y;        // pc + 4
    end

    assign srca = ctrl.srca_reg ? a_q : pc_q;

    always_comb
    begin
        case (ctrl.srcb)
            srcb_reg:     srcb = b_q;
            srcb_four:    srcb = 32'd4;
            srcb_imm:     srcb = imm_ext;
            srcb_imm_sl2: srcb = {imm_ext[data_w-3:0], 2'b00};
            default:      srcb = b_q;
        endcase
    end

    assign wa = ctrl.reg_dst ? ir_q[15:11] : ir_q[20:16];   // rd or rt
    assign wd = ctrl.mem_to_reg ? mdr_q : aluout_q;

    reg_file u_reg_file
    (
        .clk   (clk),
        .reset (reset),
        .ra1   (ir_q[25:21]),    // rs
        .ra2   (ir_q[20:16]),    // rt
        .wa    (wa),
        .we    (ctrl.reg_write),
        .wd    (wd),
        .rd1   (rd1),
        .rd2   (rd2)
    );

    alu u_alu
    (
        .a    (srca),
        .b    (srcb),
        .op   (ctrl.alu_op),
        .y    (alu_y),
        .zero (alu_zero)
    );

    // unified memory port
    assign mem_req.addr  = ctrl.ior_d ? aluout_q : pc_q;
    assign mem_req.wdata = b_q;     // sw data from rt
    assign mem_req.we    = ctrl.mem_write;

endmodule

// File: datapath/reg_file.sv
// 32 x 32 register file, two async read ports, one write port on the clock edge, r0 fixed at zero
`timescale 1ns/1ps

module reg_file import mips_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  reg_idx_t ra1,
    input  reg_idx_t ra2,
    input  reg_idx_t wa,
    input  logic     we,
    input  word_t    wd,
    output word_t    rd1,
    output word_t    rd2
);

    word_t regs [2**reg_addr_w];

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            for (int i = 0; i < 2**reg_addr_w; i++)
                regs[i] <= '0;
        end
        else if (we && (wa != '0))    // r0 writes dropped
            regs[wa] <= wd;
    end

    assign rd1 = regs[ra1];
    assign rd2 = regs[ra2];    // r0 stays at its reset value

    // r0 reads back as zero on both ports
    a_r0_zero: assert property (@(posedge clk) disable iff (!reset)
        ((ra1 != '0) || (rd1 == '0)) && ((ra2 != '0) || (rd2 == '0)));

endmodule

// File: hdl/mips_core.sv
// top of the multicycle mips core, joins control unit and datapath to the unified memory port
`timescale 1ns/1ps

module mips_core import mips_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    output mem_req_t mem_req,
    input  word_t    mem_rdata    // same-cycle read data
);

    ctrl_t   ctrl;
    opcode_t opcode;     // from ir
    funct_t  funct;

    control_unit u_control_unit
    (
        .clk    (clk),
        .reset  (reset),
        .opcode (opcode),
        .funct  (funct),
        .ctrl   (ctrl)
    );

    datapath u_datapath
    (
        .clk       (clk),
        .reset     (reset),
        .ctrl      (ctrl),
        .opcode    (opcode),
        .funct     (funct),
        .mem_req   (mem_req),
        .mem_rdata (mem_rdata)
    );

endmodule

// File: project.f
common/mips_pkg.sv
control/instr_decoder.sv
control/control_unit.sv
datapath/reg_file.sv
datapath/alu.sv
datapath/datapath.sv
hdl/mips_core.sv
test/mem_model.sv
test/tb_mips_core.sv

// File: test/mem_model.sv
// testbench word memory with async read and clocked write, filled and peeked through tasks
`timescale 1ns/1ps

module mem_model import mips_pkg::*;
(
    input  logic     clk,
    input  mem_req_t req,
    output word_t    rdata
);

    localparam int depth = 256;    // 1 KB, byte addresses 0x000..0x3fc
    localparam int idx_w = 8;

    word_t mem [depth];

    assign rdata = mem[req.addr[idx_w+1:2]];    // same-cycle read, low bits ignored

    always @(posedge clk)
    begin
        if (req.we)
            mem[req.addr[idx_w+1:2]] <= req.wdata;
    end

    // every word distinct and tied to its own byte address
    task automatic fill_pattern();
        for (int i = 0; i < depth; i++)
            mem[i] = 32'h5a5a_0000 ^ word_t'(i << 2);
    endtask

    task automatic load_word(input word_t addr, input word_t data);
        mem[addr[idx_w+1:2]] = data;
    endtask

    function automatic word_t peek(input word_t addr);
        return mem[addr[idx_w+1:2]];
    endfunction

endmodule

// File: test/tb_mips_core.sv
// directed testbench for the mips core, runs small programs from memory and checks stores
`timescale 1ns/1ps

module tb_mips_core import mips_pkg::*;
();

    localparam int clk_period      = 4;
    localparam int total_instr     = 45;   // all five programs
    localparam int worst_cpi       = 7;    // lw
    localparam int per_test_cycles = 16;   // reset, idle and the closing jump loop
    localparam int n_tests         = 5;
    localparam int timeout_ns      =
        (total_instr * worst_cpi + n_tests * per_test_cycles) * clk_period + 200;

    logic     clk;
    logic     reset;
    mem_req_t mem_req;
    word_t    mem_rdata;
    word_t    prog [$];       // program image starting at address 0
    int       errors;
    int       tests_run;
    int       tests_passed;

    mips_core UUT
    (
        .clk       (clk),
        .reset     (reset),
        .mem_req   (mem_req),
        .mem_rdata (mem_rdata)
    );

    mem_model u_mem
    (
        .clk   (clk),
        .req   (mem_req),
        .rdata (mem_rdata)
    );

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    // instruction encoders in the standard mips field layout
    function automatic word_t r_type(input int rs, input int rt, input int rd, input funct_t fn);
        return {op_rtype, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic word_t i_type(input opcode_t op, input int rs, input int rt,
                                     input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    function automatic word_t j_type(input word_t target);
        return {op_j, target[27:2]};   // word index within the 256 MB region
    endfunction

    function automatic word_t sext16(input logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    // hold the core in reset while memory is refilled and the program written
    task automatic hold_reset();
        @(posedge clk);
        #1 reset = 1'b0;
        u_mem.fill_pattern();
        for (int i = 0; i < prog.size(); i++)
            u_mem.load_word(word_t'(i * 4), prog[i]);
    endtask

    task automatic release_reset();
        repeat (4)
        begin
            @(negedge clk);
            if (mem_req.we !== 1'b0)
            begin
                $display("[FAIL] %0d ns: memory write enable high during reset", $time);
                errors++;
            end
        end
        @(posedge clk);
        #1 reset = 1'b1;
    endtask

    // done once the final j has been fetched and has looped back to itself
    task automatic wait_done();
        word_t final_addr;
        final_addr = word_t'((prog.size() - 1) * 4);
        while (mem_req.addr !== final_addr + 32'd4)
            @(negedge clk);
        while (mem_req.addr !== final_addr)
            @(negedge clk);
    endtask

    task automatic check_word(input word_t addr, input word_t exp, input string what);
        word_t got;
        got = u_mem.peek(addr);
        if (got !== exp)
        begin
            $display("[FAIL] %0d ns: %s at 0x%08h is 0x%08h, expected 0x%08h",
                     $time, what, addr, got, exp);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before)
        begin
            tests_passed++;
            $display("test %-8s ok", name);
        end
        else
            $display("test %-8s %0d error(s)", name, errors - err_before);
    endtask

    task automatic test_reset();
        int err0;
        err0 = errors;
        prog.delete();
        prog.push_back(j_type(32'h0));    // halt at 0
        hold_reset();
        release_reset();
        repeat (2)
        begin
            @(negedge clk);                // idle, then fetch
            if (mem_req.addr !== 32'h0 || mem_req.we !== 1'b0)
            begin
                $display("[FAIL] %0d ns: addr 0x%08h we %b after reset, expected 0 and 0",
                         $time, mem_req.addr, mem_req.we);
                errors++;
            end
        end
        wait_done();
        finish_test("reset", err0);
    endtask

    task automatic test_arith();
        logic [15:0] imm1;
        logic [15:0] imm2;
        logic [15:0] imm3;
        word_t       a;
        word_t       b;
        int          err0;
        err0 = errors;
        imm1 = 16'($urandom) & 16'h7fff;   // positive
        imm2 = 16'($urandom) | 16'h8000;   // negative
        imm3 = 16'($urandom) | 16'h8000;
        a = sext16(imm1);
        b = sext16(imm2);
        prog.delete();
        prog.push_back(i_type(op_addi, 0, 1, imm1));
        prog.push_back(i_type(op_addi, 0, 2, imm2));
        prog.push_back(r_type(1, 2, 3, fn_add));
        prog.push_back(i_type(op_sw, 0, 3, 16'h0200));
        prog.push_back(r_type(1, 2, 4, fn_sub));
        prog.push_back(i_type(op_sw, 0, 4, 16'h0204));
        prog.push_back(r_type(1, 2, 5, fn_and));
        prog.push_back(i_type(op_sw, 0, 5, 16'h0208));
        prog.push_back(r_type(1, 2, 6, fn_or));
        prog.push_back(i_type(op_sw, 0, 6, 16'h020c));
        prog.push_back(r_type(1, 2, 7, fn_slt));
        prog.push_back(i_type(op_sw, 0, 7, 16'h0210));
        prog.push_back(r_type(2, 1, 8, fn_slt));
        prog.push_back(i_type(op_sw, 0, 8, 16'h0214));
        prog.push_back(i_type(op_addi, 1, 9, imm3));
        prog.push_back(i_type(op_sw, 0, 9, 16'h0218));
        prog.push_back(j_type(32'h40));      // jump to self in slot 16
        hold_reset();
        release_reset();
        wait_done();
        check_word(32'h200, a + b, "add");
        check_word(32'h204, a - b, "sub");
        check_word(32'h208, a & b, "and");
        check_word(32'h20c, a | b, "or");
        check_word(32'h210, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0, "slt a<b");
        check_word(32'h214, ($signed(b) < $signed(a)) ? 32'd1 : 32'd0, "slt b<a");
        check_word(32'h218, a + sext16(imm3), "addi negative");
        finish_test("arith", err0);
    endtask

    task automatic test_load_store();
        logic [15:0] imm;
        word_t       v;
        int          err0;
        err0 = errors;
        imm = (16'($urandom) & 16'hfffe) | 16'h0010;   // neither 0 nor -1
        v = sext16(imm);
        prog.delete();
        prog.push_back(i_type(op_addi, 0, 1, imm));
        prog.push_back(i_type(op_sw, 0, 1, 16'h0220));
        prog.push_back(i_type(op_addi, 0, 2, 16'h0200));   // base
        prog.push_back(i_type(op_lw, 2, 3, 16'h0020));
        prog.push_back(i_type(op_addi, 3, 3, 16'h0001));
        prog.push_back(i_type(op_sw, 2, 3, 16'h0024));
        prog.push_back(r_type(3, 3, 0, fn_add));            // r0 destination
        prog.push_back(i_type(op_sw, 2, 0, 16'h0028));
        prog.push_back(i_type(op_lw, 2, 0, 16'h0020));      // load into r0
        prog.push_back(i_type(op_sw, 2, 0, 16'h002c));
        prog.push_back(j_type(32'h28));
        hold_reset();
        release_reset();
        wait_done();
        check_word(32'h220, v, "stored word");
        check_word(32'h224, v + 32'd1, "reloaded plus one");
        check_word(32'h228, 32'h0, "r0 after add");
        check_word(32'h22c, 32'h0, "r0 after lw");
        finish_test("ldst", err0);
    endtask

    task automatic test_branch();
        int err0;
        err0 = errors;
        prog.delete();
        prog.push_back(i_type(op_addi, 0, 1, 16'd5));
        prog.push_back(i_type(op_addi, 0, 2, 16'd5));
        prog.push_back(i_type(op_addi, 0, 3, 16'd7));
        prog.push_back(i_type(op_beq, 1, 2, 16'd1));      // taken so the next addi is skipped
        prog.push_back(i_type(op_addi, 0, 4, 16'h0011));
        prog.push_back(i_type(op_beq, 1, 3, 16'd1));      // not taken
        prog.push_back(i_type(op_addi, 0, 5, 16'h0022));
        prog.push_back(i_type(op_sw, 0, 4, 16'h0230));
        prog.push_back(i_type(op_sw, 0, 5, 16'h0234));
        prog.push_back(j_type(32'h24));
        hold_reset();
        release_reset();
        wait_done();
        check_word(32'h230, 32'h0, "marker after taken beq");
        check_word(32'h234, 32'h22, "marker after untaken beq");
        finish_test("branch", err0);
    endtask

    task automatic test_jump();
        word_t pre;
        int    err0;
        err0 = errors;
        pre = $urandom;
        prog.delete();
        prog.push_back(i_type(op_addi, 0, 1, 16'h0033));
        prog.push_back(j_type(32'h10));                   // over the next two
        prog.push_back(i_type(op_sw, 0, 1, 16'h0240));
        prog.push_back(i_type(op_addi, 0, 1, 16'h0044));
        prog.push_back(i_type(op_sw, 0, 1, 16'h0244));
        prog.push_back(j_type(32'h14));
        hold_reset();
        u_mem.load_word(32'h240, pre);
        release_reset();
        wait_done();
        check_word(32'h240, pre, "skipped store target");
        check_word(32'h244, 32'h33, "store at jump target");
        finish_test("jump", err0);
    endtask

    initial
    begin
        #(timeout_ns);
        $display("run timed out after %0d ns, a program never reached its final jump",
                 timeout_ns);
        $display("FAIL: see errors above");
        $finish;
    end

    initial
    begin
        void'($urandom(25));
        reset        = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_passed = 0;
        test_reset();
        test_arith();
        test_load_store();
        test_branch();
        test_jump();
        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_passed, tests_run - tests_passed, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule
